// File: list.f
hw/mem_geom_pkg.sv
hw/mips_ls_pkg.sv
hw/byte_enable_gen.sv
hw/byte_lane_ram.sv
hw/load_data_align.sv
hw/data_mem_top.sv
tb/data_mem_checker.sv
tb/data_mem_tb.sv

// File: Makefile
# Verilator build and run of the data-memory testbench.

TOP := data_mem_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf obj_dir

// File: tb/data_mem_tb.sv
// Testbench for the data-memory stage.
// Shadow memory plus reference load model, responses checked in order.
module data_mem_tb
   import mem_geom_pkg::*;
   import mips_ls_pkg::*;
();

   localparam int AW          = 6;              // Word index bits for 64 words.
   localparam int N_WORDS     = 2 ** AW;
   localparam int N_BYTES     = N_WORDS * N_LANES;
   localparam int N_RESET     = 5;              // Cycles in reset.
   localparam int N_DIRECTED  = 160;            // Bound on fill and directed ops.
   localparam int N_RANDOM    = 400;
   localparam int N_OPS       = N_RESET + N_WORDS + N_DIRECTED + N_RANDOM;
   localparam int CLK_PERIOD  = 40;
   localparam int WATCHDOG_T  = (N_OPS + 20) * CLK_PERIOD;

   logic      clock;
   logic      rst_n;
   mem_req_t  req;
   load_rsp_t rsp;

   byte_t       shadow [N_BYTES];  // Expected memory contents.
   word_t       exp_q [$];         // Expected loads in issue order.
   int          errors;
   int          checks;
   logic [31:0] lcg_state;

   data_mem_top #(
      .ADDR_WIDTH (AW)
   ) u_dut (
      .i_clock (clock),
      .i_rst_n (rst_n),
      .i_req   (req),
      .o_rsp   (rsp)
   );

   always #(CLK_PERIOD / 2) clock = ~clock;

   //////////////////////////////////////////////////
   // Helpers.
   //////////////////////////////////////////////////

   // Halves swapped so the low result bits have long periods.
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return {lcg_state[15:0], lcg_state[31:16]};
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   function automatic mem_req_t make_req(input logic rd, input logic wr, input logic uns,
                                         input ls_size_e sz, input byte_addr_t a,
                                         input word_t d);
      mem_req_t r;
      r.read        = rd;
      r.write       = wr;
      r.is_unsigned = uns;
      r.size        = sz;
      r.addr        = a;
      r.wdata       = d;
      return r;
   endfunction

   // Expected load value, built from the shadow bytes.
   function automatic word_t ref_load(input byte_addr_t a, input ls_size_e sz,
                                      input logic uns);
      byte_t       b;
      logic [15:0] h;
      word_t       w;
      w = {shadow[{a[AW+1:2], 2'd3}], shadow[{a[AW+1:2], 2'd2}],
           shadow[{a[AW+1:2], 2'd1}], shadow[{a[AW+1:2], 2'd0}]};
      b = shadow[a[AW+1:0]];
      h = {shadow[{a[AW+1:2], a[1], 1'b1}], shadow[{a[AW+1:2], a[1], 1'b0}]};
      case (sz)
         SZ_BYTE: w = uns ? {24'h0, b} : {{24{b[7]}}, b};
         SZ_HALF: w = uns ? {16'h0, h} : {{16{h[15]}}, h};
         default: ;  // Whole word.
      endcase
      return w;
   endfunction

   task automatic shadow_write(input mem_req_t r);
      if (r.write && !r.read) begin
         case (r.size)
            SZ_WORD: begin
               for (int k = 0; k < N_LANES; k++) begin
                  shadow[{r.addr[AW+1:2], lane_idx_t'(k)}] = r.wdata[k*8 +: 8];
               end
            end
            SZ_HALF: begin  // Bit 0 ignored.
               shadow[{r.addr[AW+1:2], r.addr[1], 1'b0}] = r.wdata[7:0];
               shadow[{r.addr[AW+1:2], r.addr[1], 1'b1}] = r.wdata[15:8];
            end
            SZ_BYTE: shadow[r.addr[AW+1:0]] = r.wdata[7:0];
            default: ;  // SZ_NONE writes nothing.
         endcase
      end
   endtask

   // One request per falling edge.
   task automatic issue_req(input mem_req_t r);
      @(negedge clock);
      req = r;
      if (r.read) begin
         exp_q.push_back(ref_load(r.addr, r.size, r.is_unsigned));
      end else begin
         shadow_write(r);
      end
   endtask

   task automatic write_mem(input byte_addr_t a, input ls_size_e sz, input word_t d);
      issue_req(make_req(1'b0, 1'b1, 1'b0, sz, a, d));
   endtask

   task automatic read_mem(input byte_addr_t a, input ls_size_e sz, input logic uns);
      issue_req(make_req(1'b1, 1'b0, uns, sz, a, '0));
   endtask

   //////////////////////////////////////////////////
   // Compare process.
   //////////////////////////////////////////////////

   always @(posedge clock) begin
      word_t exp_word;
      if (rst_n && rsp.valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Error at %0t: response valid with no read pending", $time);
         end else begin
            exp_word = exp_q.pop_front();
            check_value("o_rsp.data", rsp.data, exp_word);
         end
      end
   end

   initial begin  // Watchdog.
      #(WATCHDOG_T);
      $display("Error: run did not finish within %0d time units", WATCHDOG_T);
      $display("Testbench failed");
      $finish;
   end

   //////////////////////////////////////////////////
   // Stimulus.
   //////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      clock     = 1'b0;
      rst_n     = 1'b0;
      req       = '0;
      errors    = 0;
      checks    = 0;
      lcg_state = 32'h9e4a;
      repeat (N_RESET) @(negedge clock);
      rst_n = 1'b1;

      // No pulse before the first read.
      for (int i = 0; i < 3; i++) begin
         issue_req('0);
         check_value("o_rsp.valid", word_t'(rsp.valid), 32'd0);
      end

      // Fill every word so no read sees X.
      for (int i = 0; i < N_WORDS; i++) begin
         write_mem(byte_addr_t'(i) << 2, SZ_WORD,
                   (word_t'(i) * 32'h0104_1041) ^ 32'h8c3a_5e17);
      end

      // Word write, then bytes into each lane.
      write_mem(32'h20, SZ_WORD, 32'hdead_beef);
      read_mem(32'h20, SZ_WORD, 1'b0);
      for (int k = 0; k < N_LANES; k++) begin
         write_mem(32'h20 + byte_addr_t'(k), SZ_BYTE, 32'h1234_5600 | word_t'(k));
         read_mem(32'h20, SZ_WORD, 1'b0);
      end

      // Halfword writes at each offset.
      // Bit 0 is ignored.
      for (int k = 0; k < N_LANES; k++) begin
         write_mem(32'h44 + byte_addr_t'(k), SZ_HALF, 32'hffff_a110 + word_t'(k));
         read_mem(32'h44, SZ_WORD, 1'b0);
      end

      // Sign and zero extension.
      // Every byte and half of this word has its top bit set.
      write_mem(32'h30, SZ_WORD, 32'h9a80_c3f7);
      for (int k = 0; k < N_LANES; k++) begin
         read_mem(32'h30 + byte_addr_t'(k), SZ_BYTE, 1'b0);
         read_mem(32'h30 + byte_addr_t'(k), SZ_BYTE, 1'b1);
      end
      read_mem(32'h30, SZ_HALF, 1'b0);
      read_mem(32'h30, SZ_HALF, 1'b1);
      read_mem(32'h32, SZ_HALF, 1'b0);
      read_mem(32'h33, SZ_HALF, 1'b1);

      // Read and write together, then a sizeless write.
      issue_req(make_req(1'b1, 1'b1, 1'b0, SZ_WORD, 32'h30, 32'h0bad_f00d));
      read_mem(32'h30, SZ_WORD, 1'b0);
      write_mem(32'h30, SZ_NONE, 32'h5555_5555);
      read_mem(32'h30, SZ_WORD, 1'b0);

      // Random mixed traffic.
      for (int i = 0; i < N_RANDOM; i++) begin
         r = lcg_next();
         case (r[2:0])
            3'd0, 3'd1, 3'd2, 3'd3: begin  // Reads, often back to back.
               read_mem(lcg_next(), (r[5:4] == 2'd0) ? SZ_WORD : ls_size_e'(r[5:4]), r[8]);
            end
            3'd4, 3'd5, 3'd6: begin
               write_mem(lcg_next(), ls_size_e'(r[5:4]), lcg_next());
            end
            default: begin  // Both strobes.
               issue_req(make_req(1'b1, 1'b1, r[8], SZ_WORD, lcg_next(), lcg_next()));
            end
         endcase
      end

      // Drain the last responses.
      issue_req('0);
      for (int i = 0; i < 4 && exp_q.size() != 0; i++) begin
         @(negedge clock);
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Error: %0d reads never got a response", exp_q.size());
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: tb/data_mem_checker.sv
// Protocol assertions for the data-memory stage.
// Bound into data_mem_top, sees the request, the lane mask and the response.
module data_mem_checker
   import mem_geom_pkg::*;
   import mips_ls_pkg::*;
(
   input logic       i_clock,
   input logic       i_rst_n,
   input mem_req_t   i_req,
   input lane_mask_t i_lane_we,
   input load_rsp_t  i_rsp
);

   //////////////////////////////////////////////////
   // Response timing.
   //////////////////////////////////////////////////

   // A sampled read gives a pulse on the next edge.
   a_valid_after_read : assert property (@(posedge i_clock) disable iff (!i_rst_n)
      i_req.read |=> i_rsp.valid)
      else $error("Read not followed by a response pulse");

   // No read, no pulse. Keeps it one cycle wide.
   a_valid_only_after_read : assert property (@(posedge i_clock) disable iff (!i_rst_n)
      !i_req.read |=> !i_rsp.valid)
      else $error("Response pulse without a read");

   //////////////////////////////////////////////////
   // Store side and reset.
   //////////////////////////////////////////////////

   a_no_write_on_read : assert property (@(posedge i_clock) disable iff (!i_rst_n)
      i_req.read |-> (i_lane_we == '0))  // Read wins.
      else $error("Lane write enabled during a read");

   // Synchronous reset, so checked one edge later.
   a_valid_low_in_reset : assert property (@(posedge i_clock)
      !i_rst_n |=> !i_rsp.valid)
      else $error("Response valid while in reset");

endmodule

bind data_mem_top data_mem_checker u_checker (
   .i_clock   (i_clock),
   .i_rst_n   (i_rst_n),
   .i_req     (i_req),
   .i_lane_we (lane_we),
   .i_rsp     (o_rsp)
);

// File: hw/data_mem_top.sv
// Data-memory stage of the core.
// Enable generator, four byte-lane RAMs and the load aligner.
module data_mem_top
   import mem_geom_pkg::*;
   import mips_ls_pkg::*;
#(
   parameter int ADDR_WIDTH = 8  // Word index bits, 256 words by default.
) (
   input  logic      i_clock,
   input  logic      i_rst_n,
   input  mem_req_t  i_req,
   output load_rsp_t o_rsp
);

   lane_mask_t            lane_we;     // Write enable per lane.
   word_t                 lane_wdata;  // Store data, lane-placed.
   word_t                 lane_rdata;  // Lane outputs, lane 0 low.
   logic [ADDR_WIDTH-1:0] word_idx;    // Row shared by all lanes.

   // Byte address to word row.
   assign word_idx = i_req.addr[ADDR_WIDTH+IDX_W-1:IDX_W];

   //////////////////////////////////////////////////
   // Store path.
   //////////////////////////////////////////////////

   byte_enable_gen u_byte_enable_gen (
      .i_req        (i_req),
      .o_lane_we    (lane_we),
      .o_lane_wdata (lane_wdata)
   );

   //////////////////////////////////////////////////
   // Byte lanes.
   //////////////////////////////////////////////////

   for (genvar k = 0; k < N_LANES; k++) begin : g_lane
      // Every lane reads on a load, the aligner picks bytes later.
      byte_lane_ram #(
         .ADDR_WIDTH (ADDR_WIDTH)
      ) u_lane (
         .i_clock (i_clock),
         .i_we    (lane_we[k]),
         .i_re    (i_req.read),
         .i_addr  (word_idx),
         .i_wdata (lane_wdata[k*BYTE_W +: BYTE_W]),
         .o_rdata (lane_rdata[k*BYTE_W +: BYTE_W])
      );
   end

   //////////////////////////////////////////////////
   // Load path.
   //////////////////////////////////////////////////

   // Controls are registered on the lane read edge.
   load_data_align u_load_data_align (
      .i_clock      (i_clock),
      .i_rst_n      (i_rst_n),
      .i_req        (i_req),
      .i_lane_rdata (lane_rdata),
      .o_rsp        (o_rsp)
   );

endmodule

// File: hw/load_data_align.sv
// Load drain.
// Registers the read's shape alongside the lane RAMs,
// then extracts and extends the addressed part.
module load_data_align
   import mem_geom_pkg::*;
   import mips_ls_pkg::*;
(
   input  logic      i_clock,
   input  logic      i_rst_n,
   input  mem_req_t  i_req,
   input  word_t     i_lane_rdata,
   output load_rsp_t o_rsp
);

   localparam int HALF_W = 2 * BYTE_W;

   logic      valid_q;     // Read pulse, one cycle late.
   ls_size_e  size_q;      // Size of the read in flight.
   lane_idx_t offset_q;    // Its byte offset.
   logic      unsigned_q;  // Its extension mode.

   byte_t             lane_byte;  // Byte picked by offset.
   logic [HALF_W-1:0] lane_half;  // Halfword picked by bit 1.
   word_t             load_word;

   //////////////////////////////////////////////////
   // Capture, same edge as the lane read.
   //////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= i_req.read;  // No hold, no back-pressure.
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_req.read) begin
         size_q     <= i_req.size;
         offset_q   <= i_req.addr[IDX_W-1:0];
         unsigned_q <= i_req.is_unsigned;
      end
   end

   //////////////////////////////////////////////////
   // Extraction and extension.
   //////////////////////////////////////////////////

   assign lane_byte = i_lane_rdata[offset_q*BYTE_W +: BYTE_W];
   assign lane_half = offset_q[1] ? i_lane_rdata[WORD_W-1:HALF_W]
                                  : i_lane_rdata[HALF_W-1:0];  // Bit 0 ignored.

   always_comb begin
      case (size_q)
         SZ_BYTE: begin
            if (unsigned_q) begin
               load_word = {{(WORD_W-BYTE_W){1'b0}}, lane_byte};  // LBU.
            end else begin
               load_word = {{(WORD_W-BYTE_W){lane_byte[BYTE_W-1]}}, lane_byte};
            end
         end
         SZ_HALF: begin
            if (unsigned_q) begin
               load_word = {{(WORD_W-HALF_W){1'b0}}, lane_half};  // LHU.
            end else begin
               load_word = {{(WORD_W-HALF_W){lane_half[HALF_W-1]}}, lane_half};
            end
         end
         default: begin
            load_word = i_lane_rdata;  // Word, or raw word for SZ_NONE.
         end
      endcase
   end

   assign o_rsp.valid = valid_q;
   assign o_rsp.data  = load_word;

endmodule

// File: hw/byte_lane_ram.sv
// One byte column of the data memory.
// Synchronous write, registered read.
module byte_lane_ram
   import mem_geom_pkg::*;
#(
   parameter int ADDR_WIDTH = 8  // Word index bits.
) (
   input  logic                  i_clock,
   input  logic                  i_we,
   input  logic                  i_re,
   input  logic [ADDR_WIDTH-1:0] i_addr,
   input  byte_t                 i_wdata,
   output byte_t                 o_rdata
);

   localparam int DEPTH = 2 ** ADDR_WIDTH;  // Words per lane.

   // Storage, no reset so it maps onto block RAM.
   byte_t mem [DEPTH];

   //////////////////////////////////////////////////
   // Write port.
   //////////////////////////////////////////////////

   always_ff @(posedge i_clock) begin
      if (i_we) begin
         mem[i_addr] <= i_wdata;  // Visible to a read next cycle.
      end
   end

   //////////////////////////////////////////////////
   // Read port.
   //////////////////////////////////////////////////

   // Output holds between reads.
   // The enable generator keeps i_we low on a read cycle.
   always_ff @(posedge i_clock) begin
      if (i_re) begin
         o_rdata <= mem[i_addr];
      end
   end

endmodule

// File: hw/byte_enable_gen.sv
// Store front end.
// Turns one request into lane write enables and lane-placed store data.
module byte_enable_gen
   import mem_geom_pkg::*;
   import mips_ls_pkg::*;
(
   input  mem_req_t   i_req,
   output lane_mask_t o_lane_we,
   output word_t      o_lane_wdata
);

   lane_idx_t offset;  // Addressed lane.
   logic      store;   // Write with no read.

   assign offset = i_req.addr[IDX_W-1:0];
   assign store  = i_req.write && !i_req.read;  // Read has priority.

   //////////////////////////////////////////////////
   // Write enables.
   //////////////////////////////////////////////////

   always_comb begin
      o_lane_we = '0;  // Idle or read.
      if (store) begin
         case (i_req.size)
            SZ_WORD: begin
               o_lane_we = '1;  // All lanes, offset ignored.
            end
            SZ_HALF: begin
               // Bit 0 is ignored, no misaligned trap.
               if (offset[1]) begin
                  o_lane_we = 4'b1100;  // Upper half.
               end else begin
                  o_lane_we = 4'b0011;  // Lower half.
               end
            end
            SZ_BYTE: begin
               o_lane_we = lane_mask_t'(1) << offset;  // One lane.
            end
            SZ_NONE: begin
               o_lane_we = '0;  // Invalid size writes nothing.
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Store data placement.
   //////////////////////////////////////////////////

   // The low byte or halfword is copied to every position.
   // The mask then decides which copy lands.
   always_comb begin
      case (i_req.size)
         SZ_BYTE: begin
            o_lane_wdata = {N_LANES{i_req.wdata[BYTE_W-1:0]}};
         end
         SZ_HALF: begin
            o_lane_wdata = {2{i_req.wdata[2*BYTE_W-1:0]}};
         end
         default: begin
            o_lane_wdata = i_req.wdata;  // Word, lane k gets byte k.
         end
      endcase
   end

endmodule

// File: hw/mips_ls_pkg.sv
// Load/store semantics of the data-memory stage.
package mips_ls_pkg;

   import mem_geom_pkg::*;

   //////////////////////////////////////////////////
   // Access size.
   //////////////////////////////////////////////////

   // Same codes as the low bits of the core's byte select.
   typedef enum logic [1:0] {
      SZ_NONE = 2'd0,  // No access, a write with it is dropped.
      SZ_BYTE = 2'd1,  // LB, LBU, SB.
      SZ_HALF = 2'd2,  // LH, LHU, SH.
      SZ_WORD = 2'd3   // LW, SW.
   } ls_size_e;

   //////////////////////////////////////////////////
   // Request and response.
   //////////////////////////////////////////////////

   // One request per cycle, plain level strobes.
   // Read wins when both strobes are high.
   typedef struct packed {
      logic       read;         // Load strobe.
      logic       write;        // Store strobe.
      logic       is_unsigned;  // Zero-extend loads.
      ls_size_e   size;         // Access width.
      byte_addr_t addr;         // Byte address.
      word_t      wdata;        // Store data, right-aligned.
   } mem_req_t;

   // Load result, one cycle after the read is sampled.
   typedef struct packed {
      logic  valid;  // Single-cycle pulse.
      word_t data;   // Extracted and extended value.
   } load_rsp_t;

endpackage

// File: hw/mem_geom_pkg.sv
// Geometry of the data memory.
// One word is split into byte-wide lanes, one column RAM per lane.
package mem_geom_pkg;

   //////////////////////////////////////////////////
   // Sizes.
   //////////////////////////////////////////////////

   localparam int BYTE_W  = 8;                 // Bits per lane.
   localparam int N_LANES = 4;                 // Fixed, halfword masks assume 32 bits.
   localparam int WORD_W  = N_LANES * BYTE_W;  // Full data word.
   localparam int IDX_W   = $clog2(N_LANES);   // Byte offset bits.

   //////////////////////////////////////////////////
   // Vector types.
   //////////////////////////////////////////////////

   typedef logic [BYTE_W-1:0]  byte_t;       // One lane of data.
   typedef logic [WORD_W-1:0]  word_t;       // Whole word, lane 0 in the low byte.
   typedef logic [N_LANES-1:0] lane_mask_t;  // Per-lane write enables.
   typedef logic [IDX_W-1:0]   lane_idx_t;   // Offset of a byte in its word.

   // Byte address as the core issues it.
   // Bits [1:0] pick the lane, the bits above pick the word.
   typedef logic [31:0]        byte_addr_t;

endpackage
